// File: src/dcache_pkg.sv
// data cache shared definitions
// cache geometry, the two views of an address, and the request,
// response and stage payload structs

`default_nettype none

package dcache_pkg;

  // ==============================
  // geometry
  // ==============================
  localparam int IDX_W      = 4;
  localparam int LINE_WORDS = 4;
  localparam int OFS_W      = 4;
  localparam int TAG_W      = 24;
  localparam int WAYS       = 2;

  // derived from the above
  localparam int SETS   = 1 << IDX_W;
  localparam int WSEL_W = OFS_W - 2;

  typedef enum logic [2:0] {
    SZ_B  = 3'd0,
    SZ_H  = 3'd1,
    SZ_W  = 3'd2,
    SZ_BU = 3'd3,
    SZ_HU = 3'd4
  } size_e;

  // ==============================
  // address views
  // ==============================
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [IDX_W-1:0]  idx;
    logic [WSEL_W-1:0] wsel;
    logic [1:0]        bsel;
  } addr_fields_s;

  // same 32 bits seen flat or split into tag/index/offset
  typedef union packed {
    logic [31:0]  word;
    addr_fields_s f;
  } mem_addr_u;

  typedef logic [LINE_WORDS-1:0][31:0] line_t;

  // ==============================
  // stage payloads
  // ==============================
  typedef struct packed {
    logic        valid;
    logic        is_store;
    size_e       size;
    mem_addr_u   addr;
    logic [31:0] wdata;
  } dcache_req_s;

  typedef struct packed {
    logic        valid;
    logic        is_store;
    logic [31:0] rdata;
  } dcache_rsp_s;

  // way is the hit way on a hit and the victim way on a miss
  typedef struct packed {
    logic             valid;
    logic             is_store;
    size_e            size;
    mem_addr_u        addr;
    logic [31:0]      wdata;
    logic             hit;
    logic             way;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;
  } s2_entry_s;

endpackage

`default_nettype wire

// File: src/dcache_arrays.sv
// data cache storage
// per-way tag, valid, dirty and data registers plus one LRU bit per set,
// combinational reads for stage 1 and stage 2

`timescale 1ns/1ps
`default_nettype none

module dcache_arrays (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic [dcache_pkg::IDX_W-1:0]                         rd_idx_i,
  input  logic [dcache_pkg::IDX_W-1:0]                         s2_idx_i,
  input  logic                                                 s2_way_i,
  output logic [dcache_pkg::WAYS-1:0][dcache_pkg::TAG_W-1:0]   tag_rd_o,
  output logic [dcache_pkg::WAYS-1:0]                          valid_rd_o,
  output logic [dcache_pkg::WAYS-1:0]                          dirty_rd_o,
  output logic                                                 lru_rd_o,
  output dcache_pkg::line_t                                    line_o,
  input  logic                                                 st_we_i,
  input  logic                                                 st_way_i,
  input  logic [dcache_pkg::IDX_W-1:0]                         st_idx_i,
  input  dcache_pkg::line_t                                    st_line_i,
  input  logic                                                 fill_we_i,
  input  logic [dcache_pkg::TAG_W-1:0]                         fill_tag_i,
  input  dcache_pkg::line_t                                    fill_line_i,
  input  logic                                                 lru_we_i,
  input  logic                                                 lru_wdata_i
);
  import dcache_pkg::*;

  logic [TAG_W-1:0] tag_q   [WAYS][SETS];
  logic             valid_q [WAYS][SETS];
  logic             dirty_q [WAYS][SETS];
  line_t            data_q  [WAYS][SETS];
  logic             lru_q   [SETS];

  // ==============================
  // state bits
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < WAYS; w++) begin
        for (int s = 0; s < SETS; s++) begin
          valid_q[w][s] <= 1'b0;
        end
      end
      for (int s = 0; s < SETS; s++) begin
        lru_q[s] <= 1'b0;
      end
    end else begin
      if (fill_we_i) begin
        valid_q[s2_way_i][s2_idx_i] <= 1'b1;
      end
      if (lru_we_i) begin
        lru_q[rd_idx_i] <= lru_wdata_i;
      end
    end
  end

  // ==============================
  // tag, dirty and data
  // ==============================
  always_ff @(posedge clk) begin
    if (fill_we_i) begin
      tag_q[s2_way_i][s2_idx_i]   <= fill_tag_i;
      dirty_q[s2_way_i][s2_idx_i] <= 1'b0;
      data_q[s2_way_i][s2_idx_i]  <= fill_line_i;
    end else if (st_we_i) begin
      dirty_q[st_way_i][st_idx_i] <= 1'b1;
      data_q[st_way_i][st_idx_i]  <= st_line_i;
    end
  end

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      tag_rd_o[w]   = tag_q[w][rd_idx_i];
      valid_rd_o[w] = valid_q[w][rd_idx_i];
      dirty_rd_o[w] = dirty_q[w][rd_idx_i];
    end
  end

  assign lru_rd_o = lru_q[rd_idx_i];
  assign line_o   = data_q[s2_way_i][s2_idx_i];

endmodule

`default_nettype wire

// File: src/dcache_lookup.sv
// data cache stage 1
// registers the accepted request, compares its tag against both ways,
// and picks the hit way or the LRU victim for stage 2

`timescale 1ns/1ps
`default_nettype none

module dcache_lookup (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  dcache_pkg::dcache_req_s                              req_i,
  output logic                                                 req_ready_o,
  input  logic                                                 s2_ready_i,
  input  logic [dcache_pkg::WAYS-1:0][dcache_pkg::TAG_W-1:0]   tag_rd_i,
  input  logic [dcache_pkg::WAYS-1:0]                          valid_rd_i,
  input  logic [dcache_pkg::WAYS-1:0]                          dirty_rd_i,
  input  logic                                                 lru_rd_i,
  output logic [dcache_pkg::IDX_W-1:0]                         rd_idx_o,
  output logic                                                 lru_we_o,
  output logic                                                 lru_wdata_o,
  output dcache_pkg::s2_entry_s                                entry_o
);
  import dcache_pkg::*;

  logic            s1_valid;
  dcache_req_s     s1_req;
  logic [WAYS-1:0] match;
  logic            hit;
  logic            hit_way;
  logic            use_way;

  // stage 0 accepts whenever stage 1 can move on
  assign req_ready_o = s2_ready_i;

  // ==============================
  // stage 1 register
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (s2_ready_i) begin
      s1_valid <= req_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_ready_i) begin
      s1_req <= req_i;
    end
  end

  assign rd_idx_o = s1_req.addr.f.idx;

  // ==============================
  // tag compare
  // ==============================
  always_comb begin
    hit_way = 1'b0;
    for (int w = 0; w < WAYS; w++) begin
      match[w] = valid_rd_i[w] & (tag_rd_i[w] == s1_req.addr.f.tag);
      if (match[w]) begin
        hit_way = 1'(w);
      end
    end
    hit = |match;
    // miss replaces the way the LRU bit points at
    use_way = hit ? hit_way : lru_rd_i;
  end

  // update only when the entry moves on, a stalled miss would flip it
  assign lru_we_o    = s1_valid & s2_ready_i;
  assign lru_wdata_o = ~use_way;

  always_comb begin
    entry_o.valid        = s1_valid;
    entry_o.is_store     = s1_req.is_store;
    entry_o.size         = s1_req.size;
    entry_o.addr         = s1_req.addr;
    entry_o.wdata        = s1_req.wdata;
    entry_o.hit          = hit;
    entry_o.way          = use_way;
    entry_o.victim_dirty = ~hit & valid_rd_i[use_way] & dirty_rd_i[use_way];
    entry_o.victim_tag   = tag_rd_i[use_way];
  end

endmodule

`default_nettype wire

// File: src/dcache_respond.sv
// data cache stage 2
// answers hits, holds a miss until the refill is done, extracts and
// extends load data and merges store bytes into the line

`timescale 1ns/1ps
`default_nettype none

module dcache_respond (
  input  logic                            clk,
  input  logic                            rst_n,
  input  dcache_pkg::s2_entry_s           entry_i,
  input  dcache_pkg::line_t               line_i,
  input  logic                            refill_done_i,
  output logic                            s2_ready_o,
  output logic                            miss_o,
  output dcache_pkg::s2_entry_s           victim_o,
  output logic                            st_we_o,
  output logic                            st_way_o,
  output logic [dcache_pkg::IDX_W-1:0]    st_idx_o,
  output dcache_pkg::line_t               st_line_o,
  output dcache_pkg::dcache_rsp_s         rsp_o
);
  import dcache_pkg::*;

  logic            s2_valid;
  s2_entry_s       s2_q;
  logic            done;
  logic [31:0]     word;
  logic [31:0]     lane;
  logic [31:0]     ld_data;
  logic [3:0][7:0] st_word;

  // ==============================
  // stage 2 register
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else if (s2_ready_o) begin
      s2_valid <= entry_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_ready_o) begin
      s2_q <= entry_i;
    end
  end

  assign miss_o     = s2_valid & ~s2_q.hit;
  assign s2_ready_o = ~miss_o | refill_done_i;
  // after refill the victim way holds the requested line
  assign done       = s2_valid & (s2_q.hit | refill_done_i);

  always_comb begin
    victim_o       = s2_q;
    victim_o.valid = s2_valid;
  end

  // ==============================
  // load path
  // ==============================
  assign word = line_i[s2_q.addr.f.wsel];
  assign lane = word >> {s2_q.addr.f.bsel, 3'b000};

  always_comb begin
    case (s2_q.size)
      SZ_B:    ld_data = {{24{lane[7]}}, lane[7:0]};
      SZ_BU:   ld_data = {24'd0, lane[7:0]};
      SZ_H:    ld_data = {{16{lane[15]}}, lane[15:0]};
      SZ_HU:   ld_data = {16'd0, lane[15:0]};
      default: ld_data = word;
    endcase
  end

  // ==============================
  // store path
  // ==============================
  always_comb begin
    st_word = word;
    case (s2_q.size)
      SZ_B, SZ_BU: begin
        st_word[s2_q.addr.f.bsel] = s2_q.wdata[7:0];
      end
      SZ_H, SZ_HU: begin
        // halfwords sit on even byte lanes
        st_word[{s2_q.addr.f.bsel[1], 1'b0}] = s2_q.wdata[7:0];
        st_word[{s2_q.addr.f.bsel[1], 1'b1}] = s2_q.wdata[15:8];
      end
      default: begin
        st_word = s2_q.wdata;
      end
    endcase
    st_line_o = line_i;
    st_line_o[s2_q.addr.f.wsel] = st_word;
  end

  assign st_we_o  = done & s2_q.is_store;
  assign st_way_o = s2_q.way;
  assign st_idx_o = s2_q.addr.f.idx;

  assign rsp_o.valid    = done;
  assign rsp_o.is_store = s2_q.is_store;
  assign rsp_o.rdata    = s2_q.is_store ? 32'd0 : ld_data;

endmodule

`default_nettype wire

// File: src/dcache_miss_engine.sv
// data cache miss engine
// writes back a dirty victim line, fetches the missing line as a
// word burst and installs it clean in the victim way

`timescale 1ns/1ps
`default_nettype none

module dcache_miss_engine (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  miss_i,
  input  dcache_pkg::s2_entry_s victim_i,
  input  dcache_pkg::line_t     wb_line_i,
  output logic                  mem_rd_o,
  output logic                  mem_wr_o,
  output logic [31:0]           mem_addr_o,
  output logic [31:0]           mem_wdata_o,
  input  logic                  mem_rvalid_i,
  input  logic [31:0]           mem_rdata_i,
  output logic                  fill_we_o,
  output dcache_pkg::line_t     fill_line_o,
  output logic                  refill_done_o
);
  import dcache_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WRITEBACK,
    FETCH,
    REFILL
  } state_e;

  state_e            state_q;
  state_e            state_d;
  logic [WSEL_W-1:0] beat_q;
  logic              last_beat;
  logic              rd_q;
  line_t             rbuf_q;
  mem_addr_u         wb_addr;
  mem_addr_u         rd_addr;

  assign last_beat = (beat_q == WSEL_W'(LINE_WORDS - 1));

  // ==============================
  // FSM
  // ==============================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (miss_i) begin
          state_d = victim_i.victim_dirty ? WRITEBACK : FETCH;
        end
      end
      WRITEBACK: begin
        if (last_beat) begin
          state_d = FETCH;
        end
      end
      FETCH: begin
        if (mem_rvalid_i && last_beat) begin
          state_d = REFILL;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      beat_q  <= '0;
      rd_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      // one read request on entry to FETCH
      rd_q    <= (state_d == FETCH) && (state_q != FETCH);
      // counter wraps to zero at the end of each burst
      if (state_q == WRITEBACK || (state_q == FETCH && mem_rvalid_i)) begin
        beat_q <= beat_q + 1'b1;
      end else if (state_q != FETCH) begin
        beat_q <= '0;
      end
    end
  end

  // incoming words
  always_ff @(posedge clk) begin
    if (state_q == FETCH && mem_rvalid_i) begin
      rbuf_q[beat_q] <= mem_rdata_i;
    end
  end

  // ==============================
  // memory port
  // ==============================
  always_comb begin
    wb_addr.f.tag  = victim_i.victim_tag;
    wb_addr.f.idx  = victim_i.addr.f.idx;
    wb_addr.f.wsel = beat_q;
    wb_addr.f.bsel = 2'b00;
    // fetch starts at the line base
    rd_addr        = victim_i.addr;
    rd_addr.f.wsel = '0;
    rd_addr.f.bsel = 2'b00;
  end

  assign mem_rd_o    = rd_q;
  assign mem_wr_o    = (state_q == WRITEBACK);
  assign mem_addr_o  = (state_q == WRITEBACK) ? wb_addr.word : rd_addr.word;
  assign mem_wdata_o = wb_line_i[beat_q];

  // ==============================
  // array fill
  // ==============================
  // line is written with the last word, so stage 2 sees it next cycle
  assign fill_we_o = (state_q == FETCH) & mem_rvalid_i & last_beat;

  always_comb begin
    fill_line_o = rbuf_q;
    fill_line_o[LINE_WORDS-1] = mem_rdata_i;
  end

  assign refill_done_o = (state_q == REFILL);

endmodule

`default_nettype wire

// File: src/dcache_top.sv
// data cache top level
// two-way set-associative, write-back, write-allocate cache with a
// three-stage request pipeline and a line-burst memory port

`timescale 1ns/1ps
`default_nettype none

module dcache_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  dcache_pkg::dcache_req_s req_i,
  output logic                    req_ready_o,
  output dcache_pkg::dcache_rsp_s rsp_o,
  output logic                    mem_rd_o,
  output logic                    mem_wr_o,
  output logic [31:0]             mem_addr_o,
  output logic [31:0]             mem_wdata_o,
  input  logic                    mem_rvalid_i,
  input  logic [31:0]             mem_rdata_i
);
  import dcache_pkg::*;

  // pipeline
  logic                        s2_ready;
  s2_entry_s                   entry;
  s2_entry_s                   s2_ent;
  logic                        miss;
  line_t                       line;
  // array ports
  logic [WAYS-1:0][TAG_W-1:0]  tag_rd;
  logic [WAYS-1:0]             valid_rd;
  logic [WAYS-1:0]             dirty_rd;
  logic                        lru_rd;
  logic [IDX_W-1:0]            rd_idx;
  logic                        lru_we;
  logic                        lru_wdata;
  logic                        st_we;
  logic                        st_way;
  logic [IDX_W-1:0]            st_idx;
  line_t                       st_line;
  logic                        fill_we;
  line_t                       fill_line;
  logic                        refill_done;

  dcache_lookup u_lookup (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .s2_ready_i  (s2_ready),
    .tag_rd_i    (tag_rd),
    .valid_rd_i  (valid_rd),
    .dirty_rd_i  (dirty_rd),
    .lru_rd_i    (lru_rd),
    .rd_idx_o    (rd_idx),
    .lru_we_o    (lru_we),
    .lru_wdata_o (lru_wdata),
    .entry_o     (entry)
  );

  dcache_respond u_respond (
    .clk           (clk),
    .rst_n         (rst_n),
    .entry_i       (entry),
    .line_i        (line),
    .refill_done_i (refill_done),
    .s2_ready_o    (s2_ready),
    .miss_o        (miss),
    .victim_o      (s2_ent),
    .st_we_o       (st_we),
    .st_way_o      (st_way),
    .st_idx_o      (st_idx),
    .st_line_o     (st_line),
    .rsp_o         (rsp_o)
  );

  dcache_miss_engine u_miss_engine (
    .clk           (clk),
    .rst_n         (rst_n),
    .miss_i        (miss),
    .victim_i      (s2_ent),
    .wb_line_i     (line),
    .mem_rd_o      (mem_rd_o),
    .mem_wr_o      (mem_wr_o),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .fill_we_o     (fill_we),
    .fill_line_o   (fill_line),
    .refill_done_o (refill_done)
  );

  // fill target is always the stage-2 set and way
  dcache_arrays u_arrays (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_idx_i    (rd_idx),
    .s2_idx_i    (s2_ent.addr.f.idx),
    .s2_way_i    (s2_ent.way),
    .tag_rd_o    (tag_rd),
    .valid_rd_o  (valid_rd),
    .dirty_rd_o  (dirty_rd),
    .lru_rd_o    (lru_rd),
    .line_o      (line),
    .st_we_i     (st_we),
    .st_way_i    (st_way),
    .st_idx_i    (st_idx),
    .st_line_i   (st_line),
    .fill_we_i   (fill_we),
    .fill_tag_i  (s2_ent.addr.f.tag),
    .fill_line_i (fill_line),
    .lru_we_i    (lru_we),
    .lru_wdata_i (lru_wdata)
  );

endmodule

`default_nettype wire

// File: bench/dcache_tb_mem.sv
// backing memory for the data cache testbench
// word image seeded from each word's address, logs every writeback word
// and returns line bursts with random gaps between the words

`timescale 1ns/1ps
`default_nettype none

module dcache_tb_mem #(
  parameter logic [31:0] FILL_KEY = 32'h8f3c_a5e1,
  parameter int          WORDS    = 1024,
  parameter int          LOG_MAX  = 64
) (
  input  logic        clk,
  input  logic        mem_rd_i,
  input  logic        mem_wr_i,
  input  logic [31:0] mem_addr_i,
  input  logic [31:0] mem_wdata_i,
  output logic        mem_rvalid_o,
  output logic [31:0] mem_rdata_o
);
  import dcache_pkg::*;

  localparam logic [31:0] SEED = 32'hbc6e_9bb8;

  logic [31:0] image    [WORDS];
  logic [31:0] log_addr [LOG_MAX];
  logic [31:0] log_data [LOG_MAX];
  int          log_count = 0;

  // words above the image keep their initial pattern
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (addr[31:2] < WORDS) begin
      return image[addr[31:2]];
    end
    return {addr[31:2], 2'b00} ^ FILL_KEY;
  endfunction

  initial begin
    for (int i = 0; i < WORDS; i++) begin
      image[i] = (32'(i) << 2) ^ FILL_KEY;
    end
  end

  // writeback words, one per strobe
  always @(negedge clk) begin
    if (mem_wr_i) begin
      if (mem_addr_i[31:2] < WORDS) begin
        image[mem_addr_i[31:2]] = mem_wdata_i;
      end
      if (log_count < LOG_MAX) begin
        log_addr[log_count] = mem_addr_i;
        log_data[log_count] = mem_wdata_i;
      end
      log_count++;
    end
  end

  // ==============================
  // read bursts
  // ==============================
  initial begin
    logic [31:0] base;
    int          gap;
    mem_rvalid_o = 1'b0;
    mem_rdata_o  = '0;
    void'($urandom(SEED));
    forever begin
      @(negedge clk);
      if (mem_rd_i) begin
        base = mem_addr_i;
        for (int i = 0; i < LINE_WORDS; i++) begin
          gap = $urandom % 6;
          @(negedge clk);
          mem_rvalid_o <= 1'b0;
          repeat (gap) @(negedge clk);
          mem_rvalid_o <= 1'b1;
          mem_rdata_o  <= read_word(base + 32'(4 * i));
        end
        @(negedge clk);
        mem_rvalid_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/dcache_tb.sv
// data cache testbench
// directed tests for load misses and hits, size extension, store merge,
// dirty eviction and back-to-back hits, checked against a byte mirror

`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
  import dcache_pkg::*;

  localparam logic [31:0] FILL_KEY  = 32'h8f3c_25e1;
  localparam int          MEM_BYTES = 4096;
  localparam int          BURST     = 8;
  localparam int          NUM_TESTS = 5;
  // writeback beats, a burst with the widest gaps, pipeline slack
  localparam int          MISS_CYCLES = LINE_WORDS + LINE_WORDS * 6 + 8;
  localparam int          TIMEOUT     = NUM_TESTS * 16 * MISS_CYCLES;

  logic        clk;
  logic        rst_n;
  dcache_req_s req;
  logic        req_ready;
  dcache_rsp_s rsp;
  logic        mem_rd;
  logic        mem_wr;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_rvalid;
  logic [31:0] mem_rdata;

  logic [7:0]  mirror [MEM_BYTES];
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          rd_strobes = 0;

  dcache_top UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req),
    .req_ready_o  (req_ready),
    .rsp_o        (rsp),
    .mem_rd_o     (mem_rd),
    .mem_wr_o     (mem_wr),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata)
  );

  dcache_tb_mem #(.FILL_KEY(FILL_KEY)) u_mem (
    .clk          (clk),
    .mem_rd_i     (mem_rd),
    .mem_wr_i     (mem_wr),
    .mem_addr_i   (mem_addr),
    .mem_wdata_i  (mem_wdata),
    .mem_rvalid_o (mem_rvalid),
    .mem_rdata_o  (mem_rdata)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("run did not finish within %0d cycles", TIMEOUT);
      $display("TEST FAILED");
      $finish;
    end
  end

  // cycles with a line read request
  always @(posedge clk) begin
    if (mem_rd) begin
      rd_strobes++;
    end
  end

  // ==============================
  // mirror and prediction
  // ==============================
  task automatic seed_mirror();
    logic [31:0] w;
    for (int a = 0; a < MEM_BYTES; a++) begin
      // each word starts as its own address xor the key
      w = (32'(a) & ~32'h3) ^ FILL_KEY;
      mirror[a] = w[8 * (a % 4) +: 8];
    end
  endtask

  function automatic logic [31:0] mirror_read(input logic [31:0] addr);
    int b;
    b = int'(addr[11:2]) * 4;
    return {mirror[b + 3], mirror[b + 2], mirror[b + 1], mirror[b]};
  endfunction

  // little-endian lanes, sign or zero extended
  function automatic logic [31:0] predict_load(input size_e size, input logic [31:0] addr);
    logic [7:0] lo;
    logic [7:0] hi;
    lo = mirror[int'(addr[11:0])];
    hi = mirror[int'(addr[11:0]) + 1];
    case (size)
      SZ_B:    return {{24{lo[7]}}, lo};
      SZ_BU:   return {24'd0, lo};
      SZ_H:    return {{16{hi[7]}}, hi, lo};
      SZ_HU:   return {16'd0, hi, lo};
      default: return mirror_read(addr);
    endcase
  endfunction

  task automatic update_mirror(input size_e size, input logic [31:0] addr,
                               input logic [31:0] wdata);
    int b;
    b = int'(addr[11:0]);
    case (size)
      SZ_B, SZ_BU: begin
        mirror[b] = wdata[7:0];
      end
      SZ_H, SZ_HU: begin
        mirror[b]     = wdata[7:0];
        mirror[b + 1] = wdata[15:8];
      end
      default: begin
        for (int k = 0; k < 4; k++) begin
          mirror[(b & ~3) + k] = wdata[8 * k +: 8];
        end
      end
    endcase
  endtask

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("ERROR %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic require(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  // ==============================
  // request helpers
  // ==============================
  function automatic dcache_req_s build_req(input logic st, input size_e size,
                                            input logic [31:0] addr,
                                            input logic [31:0] wdata);
    dcache_req_s r;
    r.valid     = 1'b1;
    r.is_store  = st;
    r.size      = size;
    r.addr.word = addr;
    r.wdata     = wdata;
    return r;
  endfunction

  // starts and ends on a falling edge
  // lat counts cycles from acceptance
  task automatic access(input dcache_req_s r, output logic [31:0] rdata, output int lat);
    logic accepted;
    accepted = 1'b0;
    if (r.is_store) begin
      update_mirror(r.size, r.addr.word, r.wdata);
    end
    req = r;
    while (!accepted) begin
      accepted = req_ready;
      @(negedge clk);
    end
    req.valid = 1'b0;
    lat = 1;
    while (!rsp.valid) begin
      @(negedge clk);
      lat++;
    end
    rdata = rsp.rdata;
    compare_word("rsp_o.is_store", rsp.is_store, r.is_store);
    @(negedge clk);
  endtask

  task automatic load_expect(input size_e size, input logic [31:0] addr, output int lat);
    logic [31:0] want;
    logic [31:0] rdata;
    want = predict_load(size, addr);
    access(build_req(1'b0, size, addr, '0), rdata, lat);
    compare_word("rsp_o.rdata", rdata, want);
  endtask

  task automatic load_hit(input size_e size, input logic [31:0] addr);
    int lat;
    load_expect(size, addr, lat);
    require(lat == 2, $sformatf("load hit at %h answered %0d cycles after acceptance, not 2",
                                addr, lat));
  endtask

  task automatic load_miss(input logic [31:0] addr);
    int lat;
    int strobes;
    strobes = rd_strobes;
    load_expect(SZ_W, addr, lat);
    require(lat > 2, $sformatf("load at %h answered as a hit on an uncached line", addr));
    require(rd_strobes == strobes + 1,
            $sformatf("line fetch for %h raised mem_rd_o for %0d cycles instead of 1",
                      addr, rd_strobes - strobes));
  endtask

  task automatic store_hit(input size_e size, input logic [31:0] addr,
                           input logic [31:0] wdata);
    logic [31:0] rdata;
    int          lat;
    access(build_req(1'b1, size, addr, wdata), rdata, lat);
    require(lat == 2, $sformatf("store hit at %h answered %0d cycles after acceptance, not 2",
                                addr, lat));
  endtask

  // ==============================
  // directed tests
  // ==============================
  task automatic miss_then_hits();
    load_miss(32'h0000_0040);
    load_hit(SZ_W, 32'h0000_0040);
    for (int k = 1; k < LINE_WORDS; k++) begin
      load_hit(SZ_W, 32'h0000_0040 + 32'(4 * k));
    end
  endtask

  task automatic size_extension();
    logic [31:0] a;
    load_miss(32'h0000_0080);
    for (int w = 0; w < LINE_WORDS; w++) begin
      for (int b = 0; b < 4; b++) begin
        a = 32'h0000_0080 + 32'(4 * w + b);
        load_hit(SZ_B, a);
        load_hit(SZ_BU, a);
        if (b % 2 == 0) begin
          load_hit(SZ_H, a);
          load_hit(SZ_HU, a);
        end
      end
    end
  endtask

  task automatic store_then_load();
    store_hit(SZ_B, 32'h0000_0085, 32'h0000_005a);
    load_hit(SZ_W, 32'h0000_0084);
    store_hit(SZ_H, 32'h0000_008a, 32'h0000_c3d2);
    load_hit(SZ_W, 32'h0000_0088);
    store_hit(SZ_W, 32'h0000_008c, 32'h1234_abcd);
    load_hit(SZ_W, 32'h0000_008c);
    load_hit(SZ_B, 32'h0000_008b);
  endtask

  // three lines of set 12
  // the stored-to line is evicted dirty
  task automatic dirty_eviction();
    int first;
    load_miss(32'h0000_00c0);
    store_hit(SZ_W, 32'h0000_00c4, 32'hdead_0001);
    store_hit(SZ_B, 32'h0000_00cb, 32'h0000_0077);
    load_miss(32'h0000_01c0);
    first = u_mem.log_count;
    load_miss(32'h0000_02c0);
    require(u_mem.log_count == first + LINE_WORDS,
            $sformatf("eviction wrote back %0d words instead of %0d",
                      u_mem.log_count - first, LINE_WORDS));
    for (int k = 0; k < LINE_WORDS; k++) begin
      compare_word("mem_addr_o", u_mem.log_addr[first + k], 32'h0000_00c0 + 32'(4 * k));
      compare_word("mem_wdata_o", u_mem.log_data[first + k],
                   mirror_read(32'h0000_00c0 + 32'(4 * k)));
    end
    load_miss(32'h0000_00c4);
    load_hit(SZ_BU, 32'h0000_00cb);
  endtask

  function automatic dcache_req_s burst_op(input int k);
    case (k)
      0:       return build_req(1'b0, SZ_W, 32'h0000_0100, '0);
      1:       return build_req(1'b0, SZ_W, 32'h0000_0044, '0);
      2:       return build_req(1'b1, SZ_W, 32'h0000_0108, 32'h5a5a_1234);
      3:       return build_req(1'b0, SZ_W, 32'h0000_0108, '0);
      4:       return build_req(1'b0, SZ_B, 32'h0000_010a, '0);
      5:       return build_req(1'b0, SZ_HU, 32'h0000_004e, '0);
      6:       return build_req(1'b1, SZ_H, 32'h0000_0046, 32'h0000_8001);
      default: return build_req(1'b0, SZ_H, 32'h0000_0046, '0);
    endcase
  endfunction

  // request k is due as a response two falling edges after it is driven
  task automatic hit_burst();
    dcache_req_s ops  [BURST];
    logic [31:0] want [BURST];
    load_miss(32'h0000_0100);
    for (int k = 0; k < BURST + 2; k++) begin
      if (k < BURST) begin
        ops[k] = burst_op(k);
        require(req_ready, $sformatf("cache not ready for burst request %0d", k));
        want[k] = predict_load(ops[k].size, ops[k].addr.word);
        if (ops[k].is_store) begin
          update_mirror(ops[k].size, ops[k].addr.word, ops[k].wdata);
        end
        req = ops[k];
      end else begin
        req.valid = 1'b0;
      end
      if (k >= 2) begin
        require(rsp.valid,
                $sformatf("no response in the cycle due for burst request %0d", k - 2));
        compare_word("rsp_o.is_store", rsp.is_store, ops[k - 2].is_store);
        if (!ops[k - 2].is_store) begin
          compare_word("rsp_o.rdata", rsp.rdata, want[k - 2]);
        end
      end
      @(negedge clk);
    end
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    req   = '0;
    rst_n = 1'b0;
    seed_mirror();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    require(req_ready, "cache not ready after reset");
    require(!rsp.valid && !mem_rd && !mem_wr, "response or memory strobe active after reset");

    miss_then_hits();
    size_extension();
    store_then_load();
    dirty_eviction();
    hit_burst();

    repeat (2) @(negedge clk);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dcache_top.f
src/dcache_pkg.sv
src/dcache_arrays.sv
src/dcache_lookup.sv
src/dcache_respond.sv
src/dcache_miss_engine.sv
src/dcache_top.sv
bench/dcache_tb_mem.sv
bench/dcache_tb.sv
